// ==== filelist.f ====
hw/cpu_pkg.sv
hw/sram_16b.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/alu.sv
hw/branch_unit.sv
hw/cpu.sv
tb/cpu_props.sv
tb/cpu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= cpu_tb
RTL_TOP    ?= cpu
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb import cpu_pkg::*; ();

	logic clk;
	logic reset_i;
	imem_load_t imem_load_i;
	logic hlt_o;
	logic [XLEN-1:0] pc_o;
	wb_trace_t wb_o;

	// Test table flattened across all tests
	logic [XLEN-1:0] words_q [$];
	wb_trace_t exp_q [$];
	int word_base [$];
	int word_cnt [$];
	int exp_base [$];
	int exp_cnt [$];
	logic [XLEN-1:0] exp_pc [$];
	string test_name [$];

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;

	cpu dut_i (
		.clk         (clk),
		.reset_i     (reset_i),
		.imem_load_i (imem_load_i),
		.hlt_o       (hlt_o),
		.pc_o        (pc_o),
		.wb_o        (wb_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the DUT did not halt within %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [XLEN-1:0] reg_op(opcode_e op, logic [3:0] rd, logic [3:0] rs,
			logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [XLEN-1:0] byte_op(opcode_e op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [XLEN-1:0] cond_branch(ccode_e cc, logic [8:0] off);
		return {OP_B, cc, off};
	endfunction

	// Reference results for the ALU opcodes where shifts take the 4-bit immediate
	function automatic logic [XLEN-1:0] alu_model(opcode_e op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b, logic [3:0] sh);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_XOR:  return a ^ b;
			OP_AND:  return a & b;
			OP_SLL:  return a << sh;
			OP_SRA:  return XLEN'($signed(a) >>> sh);
			OP_ROR:  return (a >> sh) | (a << (XLEN - sh));
			default: return a | b;
		endcase
	endfunction

	task automatic begin_test(string name);
		test_name.push_back(name);
		word_base.push_back(words_q.size());
		exp_base.push_back(exp_q.size());
	endtask

	// rd of zero means the instruction commits nothing
	task automatic add_instr(logic [XLEN-1:0] w, logic [3:0] rd, logic [XLEN-1:0] data);
		words_q.push_back(w);
		if (rd != 4'd0)
			exp_q.push_back('{valid: 1'b1, rd: rd, data: data});
	endtask

	task automatic add_halt();
		exp_pc.push_back(XLEN'(2 * (words_q.size() - word_base[$]) + 2));
		words_q.push_back({OP_HLT, 12'h000});
		word_cnt.push_back(words_q.size() - word_base[$]);
		exp_cnt.push_back(exp_q.size() - exp_base[$]);
	endtask

	task automatic add_random_test(int k);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [3:0] sh;
		opcode_e op;
		logic shift;
		a = XLEN'($urandom);
		b = XLEN'($urandom);
		sh = 4'($urandom);
		begin_test($sformatf("random alu %0d", k));
		add_instr(byte_op(OP_LLB, 1, a[7:0]), 1, {8'h00, a[7:0]});
		add_instr(byte_op(OP_LHB, 1, a[15:8]), 1, a);
		add_instr(byte_op(OP_LLB, 2, b[7:0]), 2, {8'h00, b[7:0]});
		add_instr(byte_op(OP_LHB, 2, b[15:8]), 2, b);
		for (int i = 0; i < 8; i++) begin
			op = opcode_e'(i);
			shift = op inside {OP_SLL, OP_SRA, OP_ROR};
			add_instr(reg_op(op, 4'(3 + i), 1, shift ? sh : 4'd2), 4'(3 + i),
				alu_model(op, a, b, sh));
		end
		add_halt();
	endtask

	task automatic build_tests();
		begin_test("arithmetic and logic");
		add_instr(byte_op(OP_LLB, 1, 8'hFF), 1, 16'h00FF);
		add_instr(byte_op(OP_LHB, 1, 8'h7F), 1, 16'h7FFF);
		add_instr(byte_op(OP_LLB, 2, 8'h01), 2, 16'h0001);
		add_instr(reg_op(OP_ADD, 3, 1, 2), 3, 16'h8000);
		add_instr(reg_op(OP_SUB, 4, 2, 1), 4, 16'h8002);
		add_instr(reg_op(OP_XOR, 5, 1, 2), 5, 16'h7FFE);
		add_instr(reg_op(OP_AND, 6, 1, 3), 6, 16'h0000);
		add_instr(reg_op(OP_OR, 7, 3, 2), 7, 16'h8001);
		add_instr(reg_op(OP_SLL, 8, 1, 4), 8, 16'hFFF0);
		add_instr(reg_op(OP_SRA, 9, 3, 3), 9, 16'hF000);
		add_instr(reg_op(OP_ROR, 10, 7, 1), 10, 16'hC000);
		// Signed overflow as seen through the OV branch
		add_instr(reg_op(OP_ADD, 11, 1, 2), 11, 16'h8000);
		add_instr(cond_branch(CC_OV, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 12, 8'hBD), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 13, 8'h0C), 13, 16'h000C);
		add_halt();

		begin_test("forwarding");
		add_instr(byte_op(OP_LLB, 1, 8'h03), 1, 16'd3);
		add_instr(byte_op(OP_LLB, 2, 8'h05), 2, 16'd5);
		add_instr(reg_op(OP_ADD, 3, 1, 2), 3, 16'd8);
		add_instr(reg_op(OP_ADD, 4, 3, 1), 4, 16'd11);
		add_instr(reg_op(OP_ADD, 5, 4, 3), 5, 16'd19);
		add_instr(reg_op(OP_ADD, 6, 5, 4), 6, 16'd30);
		add_instr(reg_op(OP_ADD, 6, 6, 5), 6, 16'd49);
		add_instr(reg_op(OP_ADD, 7, 6, 6), 7, 16'd98);
		add_halt();

		begin_test("memory");
		add_instr(byte_op(OP_LLB, 1, 8'h10), 1, 16'h0010);
		add_instr(byte_op(OP_LLB, 2, 8'hAB), 2, 16'h00AB);
		add_instr(byte_op(OP_LHB, 2, 8'h5C), 2, 16'h5CAB);
		add_instr(reg_op(OP_SW, 2, 1, 3), 0, 16'h0);
		add_instr(reg_op(OP_LW, 3, 1, 3), 3, 16'h5CAB);
		add_instr(reg_op(OP_ADD, 4, 3, 2), 4, 16'hB956);
		add_instr(reg_op(OP_SW, 4, 1, 4'hF), 0, 16'h0);
		add_instr(reg_op(OP_LW, 5, 1, 4'hF), 5, 16'hB956);
		add_instr(reg_op(OP_SUB, 6, 5, 4), 6, 16'h0000);
		add_instr(reg_op(OP_LW, 7, 0, 2), 7, 16'h0000);
		add_halt();

		// 5 - 3 leaves Z, N and V clear while 3 - 5 sets N
		begin_test("branches");
		add_instr(byte_op(OP_LLB, 1, 8'h05), 1, 16'h0005);
		add_instr(byte_op(OP_LLB, 2, 8'h03), 2, 16'h0003);
		add_instr(reg_op(OP_SUB, 3, 1, 2), 3, 16'h0002);
		add_instr(cond_branch(CC_NE, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 4, 8'hA0), 0, 16'h0);
		add_instr(cond_branch(CC_EQ, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 5, 8'hA1), 5, 16'h00A1);
		add_instr(cond_branch(CC_GT, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 6, 8'hA2), 0, 16'h0);
		add_instr(cond_branch(CC_LT, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 7, 8'hA3), 7, 16'h00A3);
		add_instr(cond_branch(CC_GE, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 8, 8'hA4), 0, 16'h0);
		add_instr(cond_branch(CC_LE, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 9, 8'hA5), 9, 16'h00A5);
		add_instr(cond_branch(CC_OV, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 10, 8'hA6), 10, 16'h00A6);
		add_instr(cond_branch(CC_ALWAYS, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 11, 8'hA7), 0, 16'h0);
		add_instr(reg_op(OP_SUB, 12, 2, 1), 12, 16'hFFFE);
		add_instr(cond_branch(CC_LT, 9'd1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 13, 8'hA8), 0, 16'h0);
		add_halt();

		begin_test("br and pcs");
		add_instr(reg_op(OP_PCS, 1, 0, 0), 1, 16'h0002);
		add_instr(byte_op(OP_LLB, 2, 8'h0C), 2, 16'h000C);
		// rd field 0xE puts ALWAYS in the condition bits
		add_instr(reg_op(OP_BR, 4'hE, 2, 0), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 3, 8'hE1), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 4, 8'hE2), 0, 16'h0);
		add_instr(byte_op(OP_LLB, 5, 8'hE3), 0, 16'h0);
		add_instr(reg_op(OP_PCS, 6, 0, 0), 6, 16'h000E);
		add_instr(reg_op(OP_ADD, 7, 6, 1), 7, 16'h0010);
		add_halt();

		for (int k = 0; k < 10; k++)
			add_random_test(k);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic compare_wb(wb_trace_t got, wb_trace_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t wb_o: got rd=%0d data=%h, expected rd=%0d data=%h",
				$time, got.rd, got.data, exp.rd, exp.data);
		end
	endtask

	task automatic compare_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic run_test(int t);
		int got;
		int base_errors;
		got = 0;
		base_errors = errors;
		next_cycle();
		reset_i = 1'b1;
		imem_load_i = '0;
		repeat (10) next_cycle();
		for (int i = 0; i < word_cnt[t]; i++) begin
			imem_load_i = '{valid: 1'b1, addr: MEM_AW'(i), data: words_q[word_base[t] + i]};
			next_cycle();
		end
		// Reset ends right after the last word since a reset cycle without a write clears the memory
		reset_i = 1'b0;
		imem_load_i = '0;
		do begin
			@(negedge clk);
			if (wb_o.valid) begin
				if (got < exp_cnt[t]) begin
					compare_wb(wb_o, exp_q[exp_base[t] + got]);
				end else begin
					errors++;
					$display("Unexpected commit beyond the expected list at %0t: rd=%0d data=%h",
						$time, wb_o.rd, wb_o.data);
				end
				got++;
			end
		end while (!hlt_o);
		// Instructions fetched behind HLT never commit and the halt holds
		repeat (3) begin
			@(negedge clk);
			compare_bit("hlt_o", hlt_o, 1'b1);
			if (wb_o.valid) begin
				errors++;
				$display("Commit after halt at %0t: rd=%0d data=%h", $time, wb_o.rd, wb_o.data);
			end
		end
		compare_word("commit count", XLEN'(got), XLEN'(exp_cnt[t]));
		compare_word("pc_o", pc_o, exp_pc[t]);
		$display("test %0d %s: %0d commits, pc %h, %s", t, test_name[t], got, pc_o,
			(errors == base_errors) ? "ok" : "mismatch");
	endtask

	initial begin
		int limit;
		reset_i = 1'b1;
		imem_load_i = '0;
		void'($urandom(19));
		build_tests();
		limit = 0;
		for (int t = 0; t < test_name.size(); t++)
			limit += 4 * word_cnt[t] + 40;
		cycle_limit = limit;
		for (int t = 0; t < test_name.size(); t++)
			run_test(t);
		$display("%0d tests, %0d checks, %0d errors", test_name.size(), checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== tb/cpu_props.sv ====
`timescale 1ns/10ps

module cpu_props import cpu_pkg::*; (
	input logic            clk,
	input logic            reset_i,
	input logic            hlt_i,
	input logic            stall_i,
	input logic [XLEN-1:0] pc_i,
	input wb_trace_t       wb_i
);

	// Pipeline is empty right after reset
	hlt_low_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> !hlt_i)
		else $error("hlt_o high in the first cycle after reset");

	no_r0_commit: assert property (@(posedge clk) disable iff (reset_i)
		wb_i.valid |-> wb_i.rd != '0)
		else $error("commit of register 0 on wb_o");

	// A load-use stall lets the load move on, so it never repeats
	single_stall: assert property (@(posedge clk) disable iff (reset_i) stall_i |=> !stall_i)
		else $error("stall held for more than one cycle");

	pc_even: assert property (@(posedge clk) disable iff (reset_i) !pc_i[0])
		else $error("odd fetch address on pc_o");

endmodule

bind cpu cpu_props props_i (
	.clk     (clk),
	.reset_i (reset_i),
	.hlt_i   (hlt_o),
	.stall_i (stall),
	.pc_i    (pc_o),
	.wb_i    (wb_o)
);

// ==== hw/cpu.sv ====
`timescale 1ns/10ps

module cpu import cpu_pkg::*; (
	input  logic            clk,
	input  logic            reset_i,
	input  imem_load_t      imem_load_i,
	output logic            hlt_o,
	output logic [XLEN-1:0] pc_o,
	output wb_trace_t       wb_o
);

	logic [XLEN-1:0] pc_q, pc_plus2;
	logic [XLEN-1:0] imem_addr, imem_rdata, dmem_rdata;
	logic [XLEN-1:0] rs_data, rt_data, ex_a, ex_b;
	logic [XLEN-1:0] alu_result, alu_addr, br_target;
	logic [REG_W-1:0] id_rs, id_rt;
	logic stall, redirect, freeze, hlt_pending;
	logic is_lxx, ex_live, flag_we, br_taken, dmem_we, rf_we;
	opcode_e id_op;
	flags_t alu_flags;
	fwd_sel_e fwd_a, fwd_b;
	ifid_t ifid_q;
	idex_t idex_q, idex_d;
	exmem_t exmem_q, exmem_d;
	memwb_t memwb_q, memwb_d;

	function automatic logic [XLEN-1:0] fwd_mux(fwd_sel_e sel, logic [XLEN-1:0] reg_val,
			logic [XLEN-1:0] exmem_val, logic [XLEN-1:0] memwb_val);
		case (sel)
			FWD_EXMEM: return exmem_val;
			FWD_MEMWB: return memwb_val;
			default:   return reg_val;
		endcase
	endfunction

	// HLT in writeback freezes every stage until reset
	assign freeze   = memwb_q.valid && memwb_q.halt;
	assign redirect = exmem_q.valid && exmem_q.br_taken;
	assign hlt_pending = (ifid_q.valid && ifid_q.instr.rtype.op == OP_HLT) ||
		(idex_q.valid && idex_q.op == OP_HLT) || (exmem_q.valid && exmem_q.halt);

	assign pc_plus2  = pc_q + XLEN'(2);
	assign imem_addr = reset_i ? XLEN'({imem_load_i.addr, 1'b0}) : pc_q;

	sram_16b imem_i (
		.clk     (clk),
		.reset_i (reset_i),
		.we_i    (reset_i && imem_load_i.valid),
		.addr_i  (imem_addr),
		.wdata_i (imem_load_i.data),
		.rdata_o (imem_rdata)
	);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= '0;
		end else if (!freeze) begin
			if (redirect)
				pc_q <= exmem_q.addr;
			else if (!stall && !hlt_pending)
				pc_q <= pc_plus2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ifid_q <= '0;
		end else if (!freeze) begin
			if (redirect) begin
				ifid_q.valid <= 1'b0;
			end else if (!stall) begin
				ifid_q.valid    <= !hlt_pending;
				ifid_q.pc_plus2 <= pc_plus2;
				ifid_q.instr    <= imem_rdata;
			end
		end
	end

	// LHB/LLB read their own destination for the byte merge, SW reads its data register
	assign id_op  = ifid_q.instr.rtype.op;
	assign is_lxx = (id_op == OP_LHB) || (id_op == OP_LLB);
	assign id_rs  = is_lxx ? ifid_q.instr.rtype.rd : ifid_q.instr.rtype.rs;
	assign id_rt  = (id_op == OP_SW) ? ifid_q.instr.rtype.rd : ifid_q.instr.rtype.rt;

	register_file rf_i (
		.clk       (clk),
		.reset_i   (reset_i),
		.rs_i      (id_rs),
		.rt_i      (id_rt),
		.rd_i      (memwb_q.rd),
		.we_i      (rf_we),
		.wdata_i   (memwb_q.data),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	hazard_unit hazard_i (
		.idex_i   (idex_q),
		.exmem_i  (exmem_q),
		.memwb_i  (memwb_q),
		.id_rs_i  (id_rs),
		.id_rt_i  (id_rt),
		.stall_o  (stall),
		.fwd_a_o  (fwd_a),
		.fwd_b_o  (fwd_b)
	);

	always_comb begin
		idex_d.valid    = ifid_q.valid && !stall && !redirect;
		idex_d.op       = id_op;
		idex_d.rs       = id_rs;
		idex_d.rt       = id_rt;
		idex_d.rd       = ifid_q.instr.rtype.rd;
		idex_d.a        = rs_data;
		idex_d.b        = rt_data;
		idex_d.pc_plus2 = ifid_q.pc_plus2;
		idex_d.cond     = ifid_q.instr.brn.cond;
		idex_d.br_off   = ifid_q.instr.brn.off;
		if (is_lxx)
			idex_d.imm = {8'h00, ifid_q.instr.lxx.imm8};
		else
			idex_d.imm = XLEN'($signed(ifid_q.instr.rtype.rt));
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			idex_q <= '0;
		else if (!freeze)
			idex_q <= idex_d;
	end

	assign ex_a = fwd_mux(fwd_a, idex_q.a, exmem_q.result, memwb_q.data);
	assign ex_b = fwd_mux(fwd_b, idex_q.b, exmem_q.result, memwb_q.data);

	alu alu_i (
		.op_i     (idex_q.op),
		.a_i      (ex_a),
		.b_i      (ex_b),
		.imm_i    (idex_q.imm),
		.result_o (alu_result),
		.addr_o   (alu_addr),
		.flags_o  (alu_flags)
	);

	assign ex_live = idex_q.valid && !redirect;
	assign flag_we = ex_live && !idex_q.op[3] && !freeze;

	branch_unit branch_i (
		.clk        (clk),
		.reset_i    (reset_i),
		.flag_we_i  (flag_we),
		.flags_i    (alu_flags),
		.op_i       (idex_q.op),
		.cond_i     (idex_q.cond),
		.br_off_i   (idex_q.br_off),
		.pc_plus2_i (idex_q.pc_plus2),
		.reg_i      (ex_a),
		.taken_o    (br_taken),
		.target_o   (br_target)
	);

	always_comb begin
		exmem_d.valid    = ex_live;
		exmem_d.op       = idex_q.op;
		exmem_d.rd       = idex_q.rd;
		exmem_d.addr     = br_taken ? br_target : alu_addr;
		exmem_d.result   = (idex_q.op == OP_PCS) ? idex_q.pc_plus2 : alu_result;
		exmem_d.sdata    = ex_b;
		exmem_d.halt     = idex_q.op == OP_HLT;
		exmem_d.br_taken = br_taken && ex_live;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			exmem_q <= '0;
		else if (!freeze)
			exmem_q <= exmem_d;
	end

	assign dmem_we = exmem_q.valid && exmem_q.op == OP_SW && !freeze;

	sram_16b dmem_i (
		.clk     (clk),
		.reset_i (reset_i),
		.we_i    (dmem_we),
		.addr_i  (exmem_q.addr),
		.wdata_i (exmem_q.sdata),
		.rdata_o (dmem_rdata)
	);

	always_comb begin
		memwb_d.valid = exmem_q.valid;
		memwb_d.op    = exmem_q.op;
		memwb_d.rd    = exmem_q.rd;
		memwb_d.data  = (exmem_q.op == OP_LW) ? dmem_rdata : exmem_q.result;
		memwb_d.halt  = exmem_q.halt;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			memwb_q <= '0;
		else if (!freeze)
			memwb_q <= memwb_d;
	end

	assign rf_we = memwb_q.valid && writes_rd(memwb_q.op) && memwb_q.rd != '0;

	assign wb_o  = '{valid: rf_we, rd: memwb_q.rd, data: memwb_q.data};
	assign hlt_o = freeze;
	assign pc_o  = pc_q;

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit import cpu_pkg::*; (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                flag_we_i,
	input  flags_t              flags_i,
	input  opcode_e             op_i,
	input  ccode_e              cond_i,
	input  logic [BR_OFF_W-1:0] br_off_i,
	input  logic [XLEN-1:0]     pc_plus2_i,
	input  logic [XLEN-1:0]     reg_i,
	output logic                taken_o,
	output logic [XLEN-1:0]     target_o
);

	flags_t flags_q;
	logic cond_met;

	always_ff @(posedge clk) begin
		if (reset_i)
			flags_q <= '0;
		else if (flag_we_i)
			flags_q <= flags_i;
	end

	always_comb begin
		case (cond_i)
			CC_NE:   cond_met = !flags_q.z;
			CC_EQ:   cond_met = flags_q.z;
			CC_GT:   cond_met = !flags_q.z && !flags_q.n;
			CC_LT:   cond_met = flags_q.n;
			CC_GE:   cond_met = flags_q.z || !flags_q.n;
			CC_LE:   cond_met = flags_q.n || flags_q.z;
			CC_OV:   cond_met = flags_q.v;
			default: cond_met = 1'b1;
		endcase
	end

	assign taken_o  = (op_i == OP_B || op_i == OP_BR) && cond_met;
	assign target_o = (op_i == OP_BR) ? reg_i :
		pc_plus2_i + XLEN'($signed({br_off_i, 1'b0}));

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
	input  opcode_e         op_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	input  logic [XLEN-1:0] imm_i,
	output logic [XLEN-1:0] result_o,
	output logic [XLEN-1:0] addr_o,
	output flags_t          flags_o
);

	logic [3:0] shamt;
	logic [XLEN-1:0] sum, diff;
	logic [2*XLEN-1:0] rot;
	logic add_ovf, sub_ovf;

	assign shamt = imm_i[3:0];
	assign sum   = a_i + b_i;
	assign diff  = a_i - b_i;
	assign rot   = {a_i, a_i} >> shamt;

	// Signed overflow
	assign add_ovf = (a_i[XLEN-1] == b_i[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);
	assign sub_ovf = (a_i[XLEN-1] != b_i[XLEN-1]) && (diff[XLEN-1] != a_i[XLEN-1]);

	// Word offset, so the immediate counts in halfwords of two bytes
	assign addr_o = a_i + {imm_i[XLEN-2:0], 1'b0};

	always_comb begin
		case (op_i)
			OP_ADD:  result_o = sum;
			OP_SUB:  result_o = diff;
			OP_XOR:  result_o = a_i ^ b_i;
			OP_AND:  result_o = a_i & b_i;
			OP_SLL:  result_o = a_i << shamt;
			OP_SRA:  result_o = $signed(a_i) >>> shamt;
			OP_ROR:  result_o = rot[XLEN-1:0];
			OP_OR:   result_o = a_i | b_i;
			OP_LHB:  result_o = {imm_i[7:0], a_i[7:0]};
			OP_LLB:  result_o = {a_i[XLEN-1:8], imm_i[7:0]};
			default: result_o = '0;
		endcase
	end

	always_comb begin
		flags_o.z = result_o == '0;
		flags_o.n = result_o[XLEN-1];
		case (op_i)
			OP_ADD:  flags_o.v = add_ovf;
			OP_SUB:  flags_o.v = sub_ovf;
			default: flags_o.v = 1'b0;
		endcase
	end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit import cpu_pkg::*; (
	input  idex_t            idex_i,
	input  exmem_t           exmem_i,
	input  memwb_t           memwb_i,
	input  logic [REG_W-1:0] id_rs_i,
	input  logic [REG_W-1:0] id_rt_i,
	output logic             stall_o,
	output fwd_sel_e         fwd_a_o,
	output fwd_sel_e         fwd_b_o
);

	logic load_in_ex;
	logic exmem_wr, memwb_wr;

	// Newer producer in EX/MEM wins over MEM/WB
	function automatic fwd_sel_e pick(logic [REG_W-1:0] src);
		if (src == '0)
			return FWD_NONE;
		if (exmem_wr && exmem_i.rd == src)
			return FWD_EXMEM;
		if (memwb_wr && memwb_i.rd == src)
			return FWD_MEMWB;
		return FWD_NONE;
	endfunction

	assign exmem_wr = exmem_i.valid && writes_rd(exmem_i.op);
	assign memwb_wr = memwb_i.valid && writes_rd(memwb_i.op);

	// Load data only exists after the memory stage, so hold decode one cycle
	assign load_in_ex = idex_i.valid && idex_i.op == OP_LW && idex_i.rd != '0;
	assign stall_o = load_in_ex && (idex_i.rd == id_rs_i || idex_i.rd == id_rt_i);

	always_comb begin
		fwd_a_o = pick(idex_i.rs);
		fwd_b_o = pick(idex_i.rt);
	end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
	input  logic             clk,
	input  logic             reset_i,
	input  logic [REG_W-1:0] rs_i,
	input  logic [REG_W-1:0] rt_i,
	input  logic [REG_W-1:0] rd_i,
	input  logic             we_i,
	input  logic [XLEN-1:0]  wdata_i,
	output logic [XLEN-1:0]  rs_data_o,
	output logic [XLEN-1:0]  rt_data_o
);

	logic [XLEN-1:0] regs [2**REG_W];

	// Same-cycle write is visible to decode
	function automatic logic [XLEN-1:0] read_port(logic [REG_W-1:0] idx);
		if (idx == '0)
			return '0;
		if (we_i && idx == rd_i)
			return wdata_i;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 2**REG_W; i++)
				regs[i] <= '0;
		end else if (we_i && rd_i != '0) begin
			regs[rd_i] <= wdata_i;
		end
	end

	always_comb begin
		rs_data_o = read_port(rs_i);
		rt_data_o = read_port(rt_i);
	end

endmodule

// ==== hw/sram_16b.sv ====
`timescale 1ns/10ps

module sram_16b import cpu_pkg::*; (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            we_i,
	input  logic [XLEN-1:0] addr_i,
	input  logic [XLEN-1:0] wdata_i,
	output logic [XLEN-1:0] rdata_o
);

	logic [XLEN-1:0] mem [MEM_DEPTH];
	logic [MEM_AW-1:0] idx;

	// Byte address with bit 0 dropped
	assign idx = addr_i[MEM_AW:1];

	// A write wins over the clear, so a loader streaming words while reset is held keeps them
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[idx] <= wdata_i;
		end else if (reset_i) begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;
		end
	end

	assign rdata_o = mem[idx];

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	localparam int XLEN      = 16;
	localparam int REG_W     = 4;
	localparam int MEM_DEPTH = 256;
	localparam int MEM_AW    = $clog2(MEM_DEPTH);
	localparam int BR_OFF_W  = 9;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_OR  = 4'h7,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_BR  = 4'hD,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} opcode_e;

	typedef enum logic [2:0] {
		CC_NE     = 3'd0,
		CC_EQ     = 3'd1,
		CC_GT     = 3'd2,
		CC_LT     = 3'd3,
		CC_GE     = 3'd4,
		CC_LE     = 3'd5,
		CC_OV     = 3'd6,
		CC_ALWAYS = 3'd7
	} ccode_e;

	// ALU ops, LW/SW (rd is the data register) and BR (rs is the target)
	typedef struct packed {
		opcode_e          op;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
	} rtype_t;

	typedef struct packed {
		opcode_e          op;
		logic [REG_W-1:0] rd;
		logic [7:0]       imm8;
	} lxx_t;

	typedef struct packed {
		opcode_e             op;
		ccode_e              cond;
		logic [BR_OFF_W-1:0] off;
	} brn_t;

	typedef union packed {
		rtype_t rtype;
		lxx_t   lxx;
		brn_t   brn;
	} instr_u;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc_plus2;
		instr_u          instr;
	} ifid_t;

	typedef struct packed {
		logic                valid;
		opcode_e             op;
		logic [REG_W-1:0]    rs;
		logic [REG_W-1:0]    rt;
		logic [REG_W-1:0]    rd;
		logic [XLEN-1:0]     a;
		logic [XLEN-1:0]     b;
		logic [XLEN-1:0]     imm;
		logic [XLEN-1:0]     pc_plus2;
		ccode_e              cond;
		logic [BR_OFF_W-1:0] br_off;
	} idex_t;

	// addr holds the branch target when br_taken is set
	typedef struct packed {
		logic             valid;
		opcode_e          op;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0]  addr;
		logic [XLEN-1:0]  result;
		logic [XLEN-1:0]  sdata;
		logic             halt;
		logic             br_taken;
	} exmem_t;

	typedef struct packed {
		logic             valid;
		opcode_e          op;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0]  data;
		logic             halt;
	} memwb_t;

	typedef enum logic [1:0] {
		FWD_NONE  = 2'd0,
		FWD_EXMEM = 2'd1,
		FWD_MEMWB = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		logic              valid;
		logic [MEM_AW-1:0] addr;
		logic [XLEN-1:0]   data;
	} imem_load_t;

	typedef struct packed {
		logic             valid;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0]  data;
	} wb_trace_t;

	function automatic logic writes_rd(opcode_e op);
		return !op[3] || (op inside {OP_LW, OP_LHB, OP_LLB, OP_PCS});
	endfunction

endpackage
